// ==== Makefile ====
TOP := tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log
	cat sim.log
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== alu_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_exec (
	input cpu_pkg::id_ex_t id_ex,
	input cpu_pkg::fwd_sel_e fwd_a,
	input cpu_pkg::fwd_sel_e fwd_b,
	input cpu_pkg::word_t ex_fwd,
	input cpu_pkg::word_t wb_fwd,
	output cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::redirect_t redirect
);

	cpu_pkg::word_t op_a;
	cpu_pkg::word_t op_b;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_out;
	logic equal;

	function automatic cpu_pkg::word_t pick_operand(input cpu_pkg::fwd_sel_e sel,
		input cpu_pkg::word_t reg_val);
		case (sel)
			cpu_pkg::FWD_EX_MEM: return ex_fwd;
			cpu_pkg::FWD_MEM_WB: return wb_fwd;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = pick_operand(fwd_a, id_ex.rd_a);
	assign op_b = pick_operand(fwd_b, id_ex.rd_b);
	assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			cpu_pkg::ALU_SUB: alu_out = op_a - alu_b;
			cpu_pkg::ALU_AND: alu_out = op_a & alu_b;
			cpu_pkg::ALU_OR: alu_out = op_a | alu_b;
			cpu_pkg::ALU_XOR: alu_out = op_a ^ alu_b;
			cpu_pkg::ALU_SLT: alu_out = cpu_pkg::word_t'($signed(op_a) < $signed(alu_b));
			cpu_pkg::ALU_PASS_B: alu_out = alu_b;
			default: alu_out = op_a + alu_b;
		endcase
	end

	// branches compare the two register operands, never the immediate
	assign equal = (op_a == op_b);

	assign redirect.taken = id_ex.ctrl.jump ||
		(id_ex.ctrl.branch && (equal ^ id_ex.ctrl.branch_ne));
	assign redirect.target = id_ex.pc + id_ex.imm;

	assign ex_mem.rd = id_ex.rd;
	// jal links pc + 4
	assign ex_mem.alu_result = id_ex.ctrl.jump ? id_ex.pc + cpu_pkg::word_t'(4) : alu_out;
	assign ex_mem.store_data = op_b;
	assign ex_mem.ctrl = id_ex.ctrl;

endmodule

`default_nettype wire

// ==== cpu_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_assertions (
	input wire logic clock,
	input wire logic reset,
	input cpu_pkg::word_t pc,
	input wire logic ren,
	input wire logic wen,
	input wire logic [`XLEN/8-1:0] byte_select
);

	int unsigned failures = 0;

	// one access per cycle, read or write
	no_read_and_write: assert property (@(posedge clock) disable iff (!reset) !(ren && wen))
		else begin
			failures++;
			$error("ren and wen high in the same cycle");
		end

	write_has_lanes: assert property (@(posedge clock) disable iff (!reset)
		wen |-> byte_select != '0)
		else begin
			failures++;
			$error("write with no byte lane enabled");
		end

	pc_aligned: assert property (@(posedge clock) disable iff (!reset) pc[1:0] == 2'b00)
		else begin
			failures++;
			$error("pc not word aligned");
		end

endmodule

bind cpu_core cpu_assertions u_assertions (
	.clock(clock),
	.reset(reset),
	.pc(pc),
	.ren(ren),
	.wen(wen),
	.byte_select(byte_select)
);

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core (
	input wire logic clock,
	input wire logic reset,
	output cpu_pkg::word_t pc,
	input cpu_pkg::word_t instr_in,
	output cpu_pkg::word_t data_addr,
	output logic ren,
	output logic wen,
	output cpu_pkg::word_t data_out,
	input cpu_pkg::word_t data_in,
	output logic [`XLEN/8-1:0] byte_select
);

	cpu_pkg::if_id_t if_id_d;
	cpu_pkg::if_id_t if_id_q;
	cpu_pkg::id_ex_t id_ex_d;
	cpu_pkg::id_ex_t id_ex_q;
	cpu_pkg::ex_mem_t ex_mem_d;
	cpu_pkg::ex_mem_t ex_mem_q;
	cpu_pkg::mem_wb_t mem_wb_d;
	cpu_pkg::mem_wb_t mem_wb_q;
	cpu_pkg::redirect_t redirect;
	cpu_pkg::fwd_sel_e fwd_a;
	cpu_pkg::fwd_sel_e fwd_b;
	cpu_pkg::reg_addr_t wb_rd;
	cpu_pkg::word_t wb_data;
	logic wb_write;
	logic stall;
	logic flush;

	fetch_unit u_fetch (
		.clock(clock),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.pc(pc)
	);

	assign if_id_d.pc = pc;
	assign if_id_d.instr = instr_in;

	pipe_reg #(.payload_t(cpu_pkg::if_id_t)) u_if_id (
		.clock(clock),
		.reset(reset),
		.hold(stall),
		.bubble(flush),
		.d(if_id_d),
		.q(if_id_q)
	);

	decode_stage u_decode (
		.clock(clock),
		.reset(reset),
		.if_id(if_id_q),
		.wb_write(wb_write),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.id_ex(id_ex_d)
	);

	hazard_unit u_hazard (
		.id_ex(id_ex_q),
		.ex_mem(ex_mem_q),
		.mem_wb(mem_wb_q),
		.if_id(if_id_q),
		.redirect(redirect),
		.stall(stall),
		.flush(flush),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	// load-use inserts a bubble here while IF/ID holds
	pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) u_id_ex (
		.clock(clock),
		.reset(reset),
		.hold(1'b0),
		.bubble(stall | flush),
		.d(id_ex_d),
		.q(id_ex_q)
	);

	alu_exec u_alu (
		.id_ex(id_ex_q),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.ex_fwd(ex_mem_q.alu_result),
		.wb_fwd(wb_data),
		.ex_mem(ex_mem_d),
		.redirect(redirect)
	);

	pipe_reg #(.payload_t(cpu_pkg::ex_mem_t)) u_ex_mem (
		.clock(clock),
		.reset(reset),
		.hold(1'b0),
		.bubble(1'b0),
		.d(ex_mem_d),
		.q(ex_mem_q)
	);

	store_align u_store (
		.ex_mem(ex_mem_q),
		.data_addr(data_addr),
		.ren(ren),
		.wen(wen),
		.byte_select(byte_select),
		.data_out(data_out)
	);

	assign mem_wb_d.rd = ex_mem_q.rd;
	assign mem_wb_d.alu_result = ex_mem_q.alu_result;
	assign mem_wb_d.load_word = data_in;
	assign mem_wb_d.byte_offset = ex_mem_q.alu_result[1:0];
	assign mem_wb_d.ctrl = ex_mem_q.ctrl;

	pipe_reg #(.payload_t(cpu_pkg::mem_wb_t)) u_mem_wb (
		.clock(clock),
		.reset(reset),
		.hold(1'b0),
		.bubble(1'b0),
		.d(mem_wb_d),
		.q(mem_wb_q)
	);

	writeback_unit u_wb (
		.mem_wb(mem_wb_q),
		.wb_write(wb_write),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register index widths
`define XLEN 32
`define REG_ADDR_W 5

// first fetch address after reset
`define INITIAL_PC 32'h0000_0000

// major opcodes of the supported RV32I subset
`define OP_REG 7'b0110011
`define OP_IMM 7'b0010011
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL 7'b1101111
`define OP_LUI 7'b0110111

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// add is code zero, so a zero payload is harmless
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic {
		MEM_BYTE,
		MEM_WORD
	} mem_size_e;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX_MEM,
		FWD_MEM_WB
	} fwd_sel_e;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic load_unsigned;
		mem_size_e mem_size;
		logic branch;
		logic branch_ne;
		logic jump;
		logic alu_src_imm;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		word_t pc;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t rd_a;
		word_t rd_b;
		word_t imm;
		ctrl_t ctrl;
	} id_ex_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t alu_result;
		word_t store_data;
		ctrl_t ctrl;
	} ex_mem_t;

	typedef struct packed {
		reg_addr_t rd;
		word_t alu_result;
		word_t load_word;
		logic [1:0] byte_offset;
		ctrl_t ctrl;
	} mem_wb_t;

	typedef struct packed {
		logic taken;
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module decode_stage (
	input wire logic clock,
	input wire logic reset,
	input cpu_pkg::if_id_t if_id,
	input wire logic wb_write,
	input cpu_pkg::reg_addr_t wb_rd,
	input cpu_pkg::word_t wb_data,
	output cpu_pkg::id_ex_t id_ex
);

	cpu_pkg::word_t regs [2**`REG_ADDR_W];
	cpu_pkg::word_t instr;
	cpu_pkg::word_t imm;
	cpu_pkg::ctrl_t ctrl;
	cpu_pkg::reg_addr_t rs1;
	cpu_pkg::reg_addr_t rs2;
	cpu_pkg::reg_addr_t rd;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign instr = if_id.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	// x0 reads zero, a same-cycle writeback is passed through
	function automatic cpu_pkg::word_t read_reg(input cpu_pkg::reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (wb_write && wb_rd == addr) begin
			return wb_data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_write && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// unsupported encodings fall out with ctrl all zero
	always_comb begin
		ctrl = '0;
		imm = '0;
		case (opcode)
			`OP_REG: begin
				ctrl.reg_write = 1'b1;
				case (funct3)
					3'b000: ctrl.alu_op = funct7[5] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
					3'b111: ctrl.alu_op = cpu_pkg::ALU_AND;
					3'b110: ctrl.alu_op = cpu_pkg::ALU_OR;
					3'b100: ctrl.alu_op = cpu_pkg::ALU_XOR;
					3'b010: ctrl.alu_op = cpu_pkg::ALU_SLT;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			`OP_IMM: begin
				// addi only
				ctrl.reg_write = (funct3 == 3'b000);
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			`OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = cpu_pkg::ALU_PASS_B;
				imm = {instr[31:12], 12'b0};
			end
			`OP_LOAD: begin
				ctrl.reg_write = (funct3 == 3'b000 || funct3 == 3'b100 || funct3 == 3'b010);
				ctrl.mem_read = ctrl.reg_write;
				ctrl.load_unsigned = funct3[2];
				ctrl.mem_size = funct3[1] ? cpu_pkg::MEM_WORD : cpu_pkg::MEM_BYTE;
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			`OP_STORE: begin
				ctrl.mem_write = (funct3 == 3'b000 || funct3 == 3'b010);
				ctrl.mem_size = funct3[1] ? cpu_pkg::MEM_WORD : cpu_pkg::MEM_BYTE;
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			`OP_BRANCH: begin
				ctrl.branch = (funct3 == 3'b000 || funct3 == 3'b001);
				ctrl.branch_ne = funct3[0];
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			`OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump = 1'b1;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

	assign id_ex.pc = if_id.pc;
	assign id_ex.rs1 = rs1;
	assign id_ex.rs2 = rs2;
	// no destination unless the instruction writes a register
	assign id_ex.rd = ctrl.reg_write ? rd : '0;
	assign id_ex.rd_a = read_reg(rs1);
	assign id_ex.rd_b = read_reg(rs2);
	assign id_ex.imm = imm;
	assign id_ex.ctrl = ctrl;

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module fetch_unit (
	input wire logic clock,
	input wire logic reset,
	input wire logic stall,
	input cpu_pkg::redirect_t redirect,
	output cpu_pkg::word_t pc
);

	cpu_pkg::word_t next_pc;

	// a redirect from EX beats a load-use stall
	always_comb begin
		if (redirect.taken) begin
			next_pc = redirect.target;
		end else if (stall) begin
			next_pc = pc;
		end else begin
			next_pc = pc + cpu_pkg::word_t'(4);
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= `INITIAL_PC;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	input cpu_pkg::id_ex_t id_ex,
	input cpu_pkg::ex_mem_t ex_mem,
	input cpu_pkg::mem_wb_t mem_wb,
	input cpu_pkg::if_id_t if_id,
	input cpu_pkg::redirect_t redirect,
	output logic stall,
	output logic flush,
	output cpu_pkg::fwd_sel_e fwd_a,
	output cpu_pkg::fwd_sel_e fwd_b
);

	cpu_pkg::reg_addr_t id_rs1;
	cpu_pkg::reg_addr_t id_rs2;
	logic load_use;

	// nearest producer wins
	function automatic cpu_pkg::fwd_sel_e pick_fwd(input cpu_pkg::reg_addr_t src);
		if (src == '0) begin
			return cpu_pkg::FWD_REG;
		end else if (ex_mem.ctrl.reg_write && ex_mem.rd == src) begin
			return cpu_pkg::FWD_EX_MEM;
		end else if (mem_wb.ctrl.reg_write && mem_wb.rd == src) begin
			return cpu_pkg::FWD_MEM_WB;
		end
		return cpu_pkg::FWD_REG;
	endfunction

	assign id_rs1 = if_id.instr[19:15];
	assign id_rs2 = if_id.instr[24:20];

	// may stall on an unused rs field, which only costs a cycle
	assign load_use = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
		(id_ex.rd == id_rs1 || id_ex.rd == id_rs2);

	assign flush = redirect.taken;
	assign stall = load_use && !redirect.taken;

	assign fwd_a = pick_fwd(id_ex.rs1);
	assign fwd_b = pick_fwd(id_ex.rs2);

endmodule

`default_nettype wire

// ==== pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

// generic stage register, bubble has priority over hold
module pipe_reg #(
	parameter type payload_t = logic
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic hold,
	input wire logic bubble,
	input payload_t d,
	output payload_t q
);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			q <= '0;
		end else if (bubble) begin
			// all-zero payload decodes as a no-op
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
cpu_pkg.sv
pipe_reg.sv
fetch_unit.sv
decode_stage.sv
hazard_unit.sv
alu_exec.sv
store_align.sv
writeback_unit.sv
cpu_core.sv
cpu_assertions.sv
tb_cpu.sv

// ==== store_align.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module store_align (
	input cpu_pkg::ex_mem_t ex_mem,
	output cpu_pkg::word_t data_addr,
	output logic ren,
	output logic wen,
	output logic [`XLEN/8-1:0] byte_select,
	output cpu_pkg::word_t data_out
);

	logic [1:0] offset;
	logic [`XLEN/8-1:0] lanes;

	assign offset = ex_mem.alu_result[1:0];
	assign data_addr = ex_mem.alu_result;
	assign ren = ex_mem.ctrl.mem_read;
	assign wen = ex_mem.ctrl.mem_write;

	// one lane for byte accesses, all four for words
	assign lanes = (ex_mem.ctrl.mem_size == cpu_pkg::MEM_WORD) ? '1 :
		(`XLEN/8)'(1) << offset;
	assign byte_select = (ren || wen) ? lanes : '0;

	// move the low byte of rs2 into the addressed lane
	assign data_out = (ex_mem.ctrl.mem_size == cpu_pkg::MEM_WORD) ? ex_mem.store_data :
		cpu_pkg::word_t'(ex_mem.store_data[7:0]) << {offset, 3'b000};

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu;

	localparam int CYCLE_LIMIT = 150;
	localparam int WATCHDOG_NS = 5 * 200 * 20;
	localparam logic [11:0] DONE_ADDR = 12'h0fc;

	logic clock;
	logic reset;
	logic refill;
	cpu_pkg::word_t pc;
	cpu_pkg::word_t instr_in;
	cpu_pkg::word_t data_addr;
	cpu_pkg::word_t data_out;
	cpu_pkg::word_t data_in;
	logic ren;
	logic wen;
	logic [`XLEN/8-1:0] byte_select;

	logic [31:0] rom [64];
	logic [7:0] dmem [256];
	int rom_len;
	int errors;
	logic [31:0] rng_state;

	cpu_core DUT (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.instr_in(instr_in),
		.data_addr(data_addr),
		.ren(ren),
		.wen(wen),
		.data_out(data_out),
		.data_in(data_in),
		.byte_select(byte_select)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// pattern seen by every address until a store changes it
	function automatic logic [7:0] fill_byte(input logic [7:0] a);
		return {a[3:0], a[7:4]} ^ 8'h96;
	endfunction

	function automatic logic [31:0] pattern_word(input logic [7:0] a);
		return {fill_byte(a + 8'd3), fill_byte(a + 8'd2), fill_byte(a + 8'd1), fill_byte(a)};
	endfunction

	// little endian
	function automatic logic [31:0] word_at(input logic [7:0] a);
		return {dmem[a + 8'd3], dmem[a + 8'd2], dmem[a + 8'd1], dmem[a]};
	endfunction

	always_comb begin
		instr_in = (pc < 32'd256) ? rom[pc[7:2]] : '0;
	end

	// read data only while the core strobes ren
	always_comb begin
		data_in = ren ? word_at({data_addr[7:2], 2'b00}) : '0;
	end

	// data memory, written mid-cycle while the MEM stage is stable
	always @(negedge clock) begin
		logic [7:0] base;
		base = {data_addr[7:2], 2'b00};
		if (refill) begin
			for (int i = 0; i < 256; i++) begin
				dmem[8'(i)] <= fill_byte(8'(i));
			end
		end else if (reset && wen) begin
			for (int k = 0; k < 4; k++) begin
				if (byte_select[k]) begin
					dmem[base + 8'(k)] <= data_out[8*k +: 8];
				end
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// RV32I encodings
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `OP_REG};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, `OP_LUI};
	endfunction

	task automatic emit(input logic [31:0] instr);
		rom[6'(rom_len)] = instr;
		rom_len++;
	endtask

	task automatic clear_program();
		for (int i = 0; i < 64; i++) begin
			rom[6'(i)] = '0;
		end
		rom_len = 0;
	endtask

	// lui rounds up so the sign-extended addi lands on the value
	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800;
		emit(u_type(upper[31:12], rd));
		emit(i_type(value[11:0], rd, 3'b000, rd, `OP_IMM));
	endtask

	task automatic append_done_store();
		emit(s_type(DONE_ADDR, 5'd0, 5'd0, 3'b010));
	endtask

	// two cycles of reset, memory refilled meanwhile
	task automatic reset_cpu();
		@(negedge clock);
		reset <= 1'b0;
		refill <= 1'b1;
		repeat (2) @(negedge clock);
		refill <= 1'b0;
		reset <= 1'b1;
	endtask

	task automatic wait_done(input string name);
		logic found;
		found = 1'b0;
		for (int i = 0; i < CYCLE_LIMIT && !found; i++) begin
			@(negedge clock);
			found = wen && data_addr == {20'b0, DONE_ADDR};
		end
		assert (found) else begin
			errors++;
			$display("%s test never reached its final store", name);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			errors++;
			$display("error: %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_word(input logic [7:0] addr, input logic [31:0] expected);
		check_value($sformatf("dmem[%h]", addr), word_at(addr), expected);
	endtask

	task automatic reset_and_first_store();
		int cycles;
		clear_program();
		emit(s_type(12'h080, 5'd0, 5'd0, 3'b010));
		append_done_store();
		reset_cpu();
		check_value("pc", pc, `INITIAL_PC);
		check_value("wen", {31'b0, wen}, 32'h0);
		check_value("ren", {31'b0, ren}, 32'h0);
		cycles = 0;
		while (!wen && cycles < 10) begin
			@(negedge clock);
			cycles++;
		end
		check_value("cycles until wen", 32'(cycles), 32'd3);
		wait_done("reset");
		check_word(8'h80, 32'h0);
	endtask

	task automatic alu_chain();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] upper;
		a = next_random();
		b = next_random();
		imm = next_random();
		upper = next_random();
		clear_program();
		load_const(5'd1, a);
		load_const(5'd2, b);
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
		emit(i_type(imm[11:0], 5'd1, 3'b000, 5'd9, `OP_IMM));
		emit(u_type(upper[31:12], 5'd10));
		// first store takes x10 straight from the lui ahead of it
		for (int r = 10; r >= 3; r--) begin
			emit(s_type(12'((r - 3) * 4), 5'(r), 5'd0, 3'b010));
		end
		append_done_store();
		reset_cpu();
		wait_done("alu");
		check_word(8'h00, a + b);
		check_word(8'h04, a - b);
		check_word(8'h08, a & b);
		check_word(8'h0c, a | b);
		check_word(8'h10, a ^ b);
		check_word(8'h14, {31'b0, $signed(a) < $signed(b)});
		check_word(8'h18, a + {{20{imm[11]}}, imm[11:0]});
		check_word(8'h1c, {upper[31:12], 12'h000});
	endtask

	task automatic load_use_sum();
		logic [31:0] k;
		k = next_random();
		clear_program();
		emit(i_type(k[11:0], 5'd0, 3'b000, 5'd2, `OP_IMM));
		emit(i_type(12'h040, 5'd0, 3'b010, 5'd1, `OP_LOAD));
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(s_type(12'h044, 5'd3, 5'd0, 3'b010));
		append_done_store();
		reset_cpu();
		wait_done("load-use");
		check_word(8'h44, pattern_word(8'h40) + {{20{k[11]}}, k[11:0]});
	endtask

	task automatic byte_lanes();
		logic [31:0] r;
		r = next_random() | 32'h80;
		clear_program();
		load_const(5'd1, r);
		emit(s_type(12'h051, 5'd1, 5'd0, 3'b000));
		emit(i_type(12'h051, 5'd0, 3'b000, 5'd2, `OP_LOAD));
		emit(i_type(12'h051, 5'd0, 3'b100, 5'd3, `OP_LOAD));
		emit(s_type(12'h060, 5'd2, 5'd0, 3'b010));
		emit(s_type(12'h064, 5'd3, 5'd0, 3'b010));
		append_done_store();
		reset_cpu();
		wait_done("byte");
		check_word(8'h50, {fill_byte(8'h53), fill_byte(8'h52), r[7:0], fill_byte(8'h50)});
		check_word(8'h60, {24'hffffff, r[7:0]});
		check_word(8'h64, {24'h000000, r[7:0]});
	endtask

	task automatic control_flow();
		logic [31:0] jal_pc;
		clear_program();
		emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, `OP_IMM));
		emit(i_type(12'd5, 5'd0, 3'b000, 5'd2, `OP_IMM));
		emit(i_type(12'd7, 5'd0, 3'b000, 5'd3, `OP_IMM));
		emit(i_type(12'h055, 5'd0, 3'b000, 5'd4, `OP_IMM));
		// taken beq skips two marker stores
		emit(b_type(13'd12, 5'd2, 5'd1, 3'b000));
		emit(s_type(12'h070, 5'd4, 5'd0, 3'b010));
		emit(s_type(12'h074, 5'd4, 5'd0, 3'b010));
		emit(b_type(13'd12, 5'd3, 5'd1, 3'b001));
		emit(s_type(12'h078, 5'd4, 5'd0, 3'b010));
		emit(s_type(12'h07c, 5'd4, 5'd0, 3'b010));
		// not taken, falls into the store
		emit(b_type(13'd8, 5'd3, 5'd1, 3'b000));
		emit(s_type(12'h080, 5'd4, 5'd0, 3'b010));
		jal_pc = 32'(rom_len * 4);
		emit(j_type(21'd12, 5'd5));
		emit(s_type(12'h084, 5'd4, 5'd0, 3'b010));
		emit(s_type(12'h088, 5'd4, 5'd0, 3'b010));
		emit(s_type(12'h08c, 5'd5, 5'd0, 3'b010));
		append_done_store();
		reset_cpu();
		wait_done("branch");
		check_word(8'h70, pattern_word(8'h70));
		check_word(8'h74, pattern_word(8'h74));
		check_word(8'h78, pattern_word(8'h78));
		check_word(8'h7c, pattern_word(8'h7c));
		check_word(8'h80, 32'h55);
		check_word(8'h84, pattern_word(8'h84));
		check_word(8'h88, pattern_word(8'h88));
		check_word(8'h8c, jal_pc + 32'd4);
	endtask

	initial begin
		int assert_failures;
		reset = 1'b0;
		refill = 1'b0;
		errors = 0;
		rng_state = 32'hc4c077c3;
		clear_program();
		reset_and_first_store();
		alu_chain();
		load_use_sum();
		byte_lanes();
		control_flow();
		assert_failures = int'(DUT.u_assertions.failures);
		errors += assert_failures;
		$display("run complete: %0d errors, %0d from bound assertions", errors, assert_failures);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== writeback_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module writeback_unit (
	input cpu_pkg::mem_wb_t mem_wb,
	output logic wb_write,
	output cpu_pkg::reg_addr_t wb_rd,
	output cpu_pkg::word_t wb_data
);

	cpu_pkg::word_t shifted;
	cpu_pkg::word_t load_val;
	logic [7:0] load_byte;

	// bring the addressed lane down to bits 7:0
	assign shifted = mem_wb.load_word >> {mem_wb.byte_offset, 3'b000};
	assign load_byte = shifted[7:0];

	always_comb begin
		if (mem_wb.ctrl.mem_size == cpu_pkg::MEM_WORD) begin
			load_val = mem_wb.load_word;
		end else if (mem_wb.ctrl.load_unsigned) begin
			load_val = {24'b0, load_byte};
		end else begin
			load_val = {{24{load_byte[7]}}, load_byte};
		end
	end

	assign wb_write = mem_wb.ctrl.reg_write;
	assign wb_rd = mem_wb.rd;
	assign wb_data = mem_wb.ctrl.mem_read ? load_val : mem_wb.alu_result;

endmodule

`default_nettype wire
